// File: project.f
+incdir+bench
common/cipher_pkg.sv
common/stream_ctrl_if.sv
common/lane_bus_if.sv
ctrl/cipher_regfile.sv
ctrl/cipher_ctrl_fsm.sv
stream/cipher_source.sv
stream/cipher_sink.sv
engine/cipher_lane.sv
src/cipher_top.sv
bench/tb_cipher_top.sv

// File: Bender.yml
package:
  name: cipher_accel

sources:
  - common/cipher_pkg.sv
  - common/stream_ctrl_if.sv
  - common/lane_bus_if.sv
  - ctrl/cipher_regfile.sv
  - ctrl/cipher_ctrl_fsm.sv
  - stream/cipher_source.sv
  - stream/cipher_sink.sv
  - engine/cipher_lane.sv
  - src/cipher_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_cipher_top.sv

// File: bench/tb_cipher_model.svh
/*
 * Reference model for the cipher testbench
 * Per-word cipher rule and the LCG behind the random stimulus
 */
`ifndef TB_CIPHER_MODEL_SVH
`define TB_CIPHER_MODEL_SVH

// 32-bit LCG step, wraps modulo 2^32
function automatic logic [31:0] lcg_step(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Left rotate, one bit at a time
function automatic logic [cipher_pkg::DATA_W-1:0] rotate_left(
  input logic [cipher_pkg::DATA_W-1:0] x,
  input int                            amt
);
  logic [cipher_pkg::DATA_W-1:0] r;
  for (int b = 0; b < cipher_pkg::DATA_W; b++) begin
    r[(b + amt) % cipher_pkg::DATA_W] = x[b];
  end
  return r;
endfunction

// Expected output word for one text, key and constant triple
function automatic logic [cipher_pkg::DATA_W-1:0] cipher_word(
  input logic [cipher_pkg::DATA_W-1:0] text,
  input logic [cipher_pkg::DATA_W-1:0] key,
  input logic [cipher_pkg::DATA_W-1:0] rc
);
  logic [cipher_pkg::DATA_W-1:0] mixed;
  mixed = rotate_left(text ^ key, cipher_pkg::ROT_AMT);
  // Sum wraps at the word width
  return mixed + rc;
endfunction

`endif

// File: bench/tb_cipher_top.sv
/*
 * Testbench for the streaming cipher accelerator
 * Memory model, random jobs, reference checks and a watchdog
 */
`timescale 1ns/100ps
`default_nettype none

module tb_cipher_top;

  localparam int MEM_WORDS = 1024;
  localparam int REGION    = 32;
  localparam int NUM_JOBS  = 13;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          cfg_we_i;
  cipher_pkg::reg_addr_e         cfg_addr_i;
  logic [cipher_pkg::DATA_W-1:0] cfg_wdata_i;
  logic                          start_i;
  logic                          busy_o;
  logic                          done_o;
  logic                          rd_req_o;
  logic [cipher_pkg::ADDR_W-1:0] rd_addr_o;
  logic [cipher_pkg::DATA_W-1:0] rd_data_i;
  logic                          wr_req_o;
  logic [cipher_pkg::ADDR_W-1:0] wr_addr_o;
  logic [cipher_pkg::DATA_W-1:0] wr_data_o;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] exp_mem [MEM_WORDS];
  logic [31:0] exp_words [$];
  logic [15:0] exp_rd_addrs [$];
  logic [15:0] exp_out_base;
  logic        rd_pend;
  logic [15:0] rd_pend_addr;
  logic [31:0] rng_state;
  int          job_len [NUM_JOBS];
  int          rd_cnt;
  int          wr_cnt;
  int          done_cnt;
  int          err_cnt;
  int          test_err_base;
  int          tests_run;
  int          tests_failed;
  int          wd_cycles;

  `include "tb_cipher_model.svh"

  cipher_top dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .start_i     (start_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .rd_req_o    (rd_req_o),
    .rd_addr_o   (rd_addr_o),
    .rd_data_i   (rd_data_i),
    .wr_req_o    (wr_req_o),
    .wr_addr_o   (wr_addr_o),
    .wr_data_o   (wr_data_o)
  );

  always #10 clk_i = ~clk_i;

  function logic [31:0] next_rand();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  function int rand_below(input int n);
    return int'(next_rand() >> 8) % n;
  endfunction

  task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  task finish_test(input string name);
    tests_run++;
    if (err_cnt == test_err_base) begin
      $display("test %-15s PASS", name);
    end else begin
      tests_failed++;
      $display("test %-15s FAIL (%0d errors)", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  task write_reg(input cipher_pkg::reg_addr_e addr, input logic [31:0] data);
    @(posedge clk_i);
    #2;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #2;
    cfg_we_i = 1'b0;
  endtask

  // Sample outputs mid-cycle, check reads and writes, latch the read request
  always @(negedge clk_i) begin
    rd_pend      = rd_req_o;
    rd_pend_addr = rd_addr_o;
    if (rd_req_o) begin
      if (rd_cnt < exp_rd_addrs.size()) begin
        check_value("rd_addr_o", rd_addr_o, exp_rd_addrs[rd_cnt]);
      end else begin
        $display("Unexpected read past the job length at address 0x%04h", rd_addr_o);
        err_cnt++;
      end
      rd_cnt++;
    end
    if (wr_req_o) begin
      if (wr_cnt < exp_words.size()) begin
        check_value("wr_addr_o", wr_addr_o, exp_out_base + wr_cnt);
        check_value("wr_data_o", wr_data_o, exp_words[wr_cnt]);
      end else begin
        $display("Unexpected write past the job length at address 0x%04h", wr_addr_o);
        err_cnt++;
      end
      mem[wr_addr_o % MEM_WORDS] = wr_data_o;
      wr_cnt++;
    end
    if (done_o) begin
      done_cnt++;
    end
  end

  // Read port with one cycle latency
  always @(posedge clk_i) begin
    #2;
    if (rd_pend) begin
      rd_data_i = mem[rd_pend_addr % MEM_WORDS];
    end
  end

  // Bases sit in separate regions for text, key, rc and output
  task run_job(input int len, input bit poke_regs);
    logic [15:0] text_b;
    logic [15:0] key_b;
    logic [15:0] rc_b;
    logic [15:0] out_b;
    int          words;
    words  = len * cipher_pkg::NUM_LANES;
    text_b = 16'(rand_below(8) * REGION + rand_below(REGION - words + 1));
    key_b  = 16'((8 + rand_below(8)) * REGION + rand_below(REGION - words + 1));
    rc_b   = 16'((16 + rand_below(8)) * REGION + rand_below(REGION - words + 1));
    out_b  = 16'((24 + rand_below(8)) * REGION + rand_below(REGION - words + 1));
    exp_words.delete();
    exp_rd_addrs.delete();
    for (int i = 0; i < words; i++) begin
      exp_words.push_back(cipher_word(mem[text_b + i], mem[key_b + i], mem[rc_b + i]));
      exp_mem[out_b + i] = exp_words[i];
      // Text, key and constant of one word are read in turn
      exp_rd_addrs.push_back(16'(text_b + i));
      exp_rd_addrs.push_back(16'(key_b + i));
      exp_rd_addrs.push_back(16'(rc_b + i));
    end
    exp_out_base = out_b;
    rd_cnt       = 0;
    wr_cnt       = 0;
    done_cnt     = 0;
    write_reg(cipher_pkg::REG_TEXT, text_b);
    write_reg(cipher_pkg::REG_KEY, key_b);
    write_reg(cipher_pkg::REG_RC, rc_b);
    write_reg(cipher_pkg::REG_OUT, out_b);
    write_reg(cipher_pkg::REG_LEN, len);
    @(posedge clk_i);
    #2;
    start_i = 1'b1;
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
    if (poke_regs) begin
      // Move the output to the neighbouring slot and lengthen the job
      write_reg(cipher_pkg::REG_OUT, out_b ^ 16'h0020);
      write_reg(cipher_pkg::REG_LEN, len + 2);
    end
    do begin
      @(negedge clk_i);
      check_value("busy_o", busy_o, 1'b1);
    end while (!done_o);
    check_value("write count at done", wr_cnt, words);
    check_value("read count at done", rd_cnt, 3 * words);
    @(negedge clk_i);
    check_value("busy_o after done", busy_o, 1'b0);
    repeat (5) @(negedge clk_i);
    check_value("done pulses", done_cnt, 1);
    check_value("write count", wr_cnt, words);
    for (int a = 0; a < MEM_WORDS; a++) begin
      check_value($sformatf("mem[0x%03h]", a), mem[a], exp_mem[a]);
      exp_mem[a] = mem[a];
    end
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = cipher_pkg::REG_TEXT;
    cfg_wdata_i = '0;
    start_i     = 1'b0;
    rd_data_i   = '0;
    rd_pend     = 1'b0;
    rng_state   = 32'd45;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]     = next_rand();
      exp_mem[a] = mem[a];
    end
    for (int j = 0; j < NUM_JOBS; j++) begin
      job_len[j] = 1 + rand_below(8);
    end
    // First of the repeated jobs is the shortest one
    job_len[3] = 1;
    for (int j = 0; j < NUM_JOBS; j++) begin
      wd_cycles += job_len[j] * 4 * cipher_pkg::NUM_LANES + 20;
    end
    wd_cycles = wd_cycles * 2;

    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (20) begin
      @(negedge clk_i);
      check_value("rd_req_o", rd_req_o, 1'b0);
      check_value("wr_req_o", wr_req_o, 1'b0);
      check_value("done_o", done_o, 1'b0);
      check_value("busy_o", busy_o, 1'b0);
    end
    finish_test("reset_state");
    run_job(job_len[0], 1'b0);
    finish_test("cipher_results");
    run_job(job_len[1], 1'b0);
    finish_test("completion");
    run_job(job_len[2], 1'b1);
    finish_test("settings_locked");
    for (int j = 3; j < NUM_JOBS; j++) begin
      run_job(job_len[j], 1'b0);
    end
    finish_test("repeated_jobs");

    $display("Summary: %0d tests run, %0d failing, %0d errors",
             tests_run, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Limit scales with the job lengths drawn at the start
  initial begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a job did not finish", wd_cycles);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/cipher_top.sv
/*
 * Streaming cipher accelerator top level
 */
`timescale 1ns/100ps
`default_nettype none

module cipher_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cfg_we_i,
  input  cipher_pkg::reg_addr_e         cfg_addr_i,
  input  logic [cipher_pkg::DATA_W-1:0] cfg_wdata_i,
  input  logic                          start_i,
  output logic                          busy_o,
  output logic                          done_o,
  output logic                          rd_req_o,
  output logic [cipher_pkg::ADDR_W-1:0] rd_addr_o,
  input  logic [cipher_pkg::DATA_W-1:0] rd_data_i,
  output logic                          wr_req_o,
  output logic [cipher_pkg::ADDR_W-1:0] wr_addr_o,
  output logic [cipher_pkg::DATA_W-1:0] wr_data_o
);

  cipher_pkg::cipher_cfg_t                                 cfg;
  logic [cipher_pkg::NUM_LANES-1:0]                        res_valid;
  logic [cipher_pkg::NUM_LANES-1:0][cipher_pkg::DATA_W-1:0] res;

  stream_ctrl_if src_ctrl ();
  stream_ctrl_if snk_ctrl ();
  lane_bus_if    beat_bus ();
  lane_bus_if    lane_bus [cipher_pkg::NUM_LANES] ();

  cipher_regfile u_regfile (
    .clk_i,
    .rst_ni,
    .cfg_we_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .busy_i (busy_o),
    .cfg_o  (cfg)
  );

  cipher_ctrl_fsm u_ctrl (
    .clk_i,
    .rst_ni,
    .start_i,
    .cfg_i    (cfg),
    .src_ctrl (src_ctrl),
    .snk_ctrl (snk_ctrl),
    .busy_o,
    .done_o
  );

  cipher_source u_source (
    .clk_i,
    .rst_ni,
    .ctrl  (src_ctrl),
    .cfg_i (cfg),
    .rd_req_o,
    .rd_addr_o,
    .rd_data_i,
    .beat  (beat_bus)
  );

  for (genvar l = 0; l < cipher_pkg::NUM_LANES; l++) begin : gen_lane
    assign lane_bus[l].beat_valid = beat_bus.beat_valid;
    // Rotate the beat so that word l lands in slot 0
    for (genvar w = 0; w < cipher_pkg::NUM_LANES; w++) begin : gen_slot
      assign lane_bus[l].text[w] = beat_bus.text[(l + w) % cipher_pkg::NUM_LANES];
      assign lane_bus[l].key[w]  = beat_bus.key[(l + w) % cipher_pkg::NUM_LANES];
      assign lane_bus[l].rc[w]   = beat_bus.rc[(l + w) % cipher_pkg::NUM_LANES];
    end

    cipher_lane u_lane (
      .clk_i,
      .rst_ni,
      .beat        (lane_bus[l]),
      .res_o       (res[l]),
      .res_valid_o (res_valid[l])
    );
  end

  // Lanes run in lockstep, lane 0 strobes the sink
  cipher_sink u_sink (
    .clk_i,
    .rst_ni,
    .ctrl        (snk_ctrl),
    .res_valid_i (res_valid[0]),
    .res_i       (res),
    .wr_req_o,
    .wr_addr_o,
    .wr_data_o
  );

endmodule

`default_nettype wire

// File: engine/cipher_lane.sv
/*
 * Cipher lane
 * Two stage pipeline: rotl(text ^ key) then add the round constant
 */
`timescale 1ns/100ps
`default_nettype none

module cipher_lane (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  lane_bus_if.lane                      beat,
  output logic [cipher_pkg::DATA_W-1:0] res_o,
  output logic                          res_valid_o
);

  logic [cipher_pkg::DATA_W-1:0] mix;
  logic [cipher_pkg::DATA_W-1:0] s1_mix_q;
  logic [cipher_pkg::DATA_W-1:0] s1_rc_q;
  logic                          s1_valid_q;

  // Own word sits in slot 0 of the lane view
  assign mix = beat.text[0] ^ beat.key[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q  <= 1'b0;
      res_valid_o <= 1'b0;
    end else begin
      s1_valid_q  <= beat.beat_valid;
      res_valid_o <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_mix_q <= (mix << cipher_pkg::ROT_AMT) | (mix >> (cipher_pkg::DATA_W - cipher_pkg::ROT_AMT));
    s1_rc_q  <= beat.rc[0];
    // Sum wraps modulo 2^32
    res_o    <= s1_mix_q + s1_rc_q;
  end

endmodule

`default_nettype wire

// File: stream/cipher_sink.sv
/*
 * Sink streamer
 * Serializes lane results to the write port and counts written beats
 */
`timescale 1ns/100ps
`default_nettype none

module cipher_sink (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  stream_ctrl_if.streamer                                         ctrl,
  input  logic                                                    res_valid_i,
  input  logic [cipher_pkg::NUM_LANES-1:0][cipher_pkg::DATA_W-1:0] res_i,
  output logic                                                    wr_req_o,
  output logic [cipher_pkg::ADDR_W-1:0]                           wr_addr_o,
  output logic [cipher_pkg::DATA_W-1:0]                           wr_data_o
);

  logic                                                    busy_q;
  logic                                                    wr_active_q;
  logic [cipher_pkg::LANE_W-1:0]                           lane_q;
  logic [cipher_pkg::ADDR_W-1:0]                           word_q;
  logic [cipher_pkg::ADDR_W-1:0]                           out_base_q;
  logic [cipher_pkg::LEN_W-1:0]                            num_beats_q;
  logic [cipher_pkg::LEN_W-1:0]                            beat_cnt_q;
  logic [cipher_pkg::NUM_LANES-1:0][cipher_pkg::DATA_W-1:0] res_q;
  logic                                                    wr_last;

  assign wr_last = wr_active_q && (lane_q == cipher_pkg::LAST_LANE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      wr_active_q <= 1'b0;
      lane_q      <= '0;
      word_q      <= '0;
      out_base_q  <= '0;
      num_beats_q <= '0;
      beat_cnt_q  <= '0;
    end else if (ctrl.req_start) begin
      busy_q      <= 1'b1;
      wr_active_q <= 1'b0;
      lane_q      <= '0;
      word_q      <= '0;
      out_base_q  <= ctrl.base_addr;
      num_beats_q <= ctrl.num_beats;
      beat_cnt_q  <= '0;
    end else begin
      if (res_valid_i) begin
        wr_active_q <= 1'b1;
      end else if (wr_last) begin
        wr_active_q <= 1'b0;
      end
      // One lane word per cycle
      if (wr_active_q) begin
        lane_q <= lane_q + 1'b1;
        word_q <= word_q + 1'b1;
      end
      if (wr_last) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        if ((beat_cnt_q + 1'b1) == num_beats_q) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_valid_i) begin
      res_q <= res_i;
    end
  end

  assign wr_req_o  = wr_active_q;
  assign wr_addr_o = out_base_q + word_q;
  assign wr_data_o = res_q[lane_q];

  assign ctrl.ready_start = !busy_q;
  assign ctrl.beat_cnt    = beat_cnt_q;

  // Source pacing must leave room to drain a beat
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i |-> !wr_active_q);

endmodule

`default_nettype wire

// File: stream/cipher_source.sv
/*
 * Source streamer
 * Reads text, key and constant words per lane and presents whole beats
 */
`timescale 1ns/100ps
`default_nettype none

module cipher_source (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  stream_ctrl_if.streamer               ctrl,
  input  cipher_pkg::cipher_cfg_t       cfg_i,
  output logic                          rd_req_o,
  output logic [cipher_pkg::ADDR_W-1:0] rd_addr_o,
  input  logic [cipher_pkg::DATA_W-1:0] rd_data_i,
  lane_bus_if.src                       beat
);

  // Read order inside one lane
  typedef enum logic [1:0] {
    STR_TEXT,
    STR_KEY,
    STR_RC
  } stream_e;

  logic                                                    busy_q;
  logic                                                    issue_q;
  stream_e                                                 str_q;
  logic [cipher_pkg::LANE_W-1:0]                           lane_q;
  logic [cipher_pkg::ADDR_W-1:0]                           word_q;
  logic [cipher_pkg::LEN_W-1:0]                            issue_beat_q;
  logic [cipher_pkg::LEN_W-1:0]                            beat_cnt_q;
  logic [cipher_pkg::ADDR_W-1:0]                           text_base_q;
  logic [cipher_pkg::LEN_W-1:0]                            num_beats_q;
  logic                                                    rsp_valid_q;
  stream_e                                                 rsp_str_q;
  logic [cipher_pkg::LANE_W-1:0]                           rsp_lane_q;
  logic                                                    beat_valid_q;
  logic [cipher_pkg::NUM_LANES-1:0][cipher_pkg::DATA_W-1:0] text_q;
  logic [cipher_pkg::NUM_LANES-1:0][cipher_pkg::DATA_W-1:0] key_q;
  logic [cipher_pkg::NUM_LANES-1:0][cipher_pkg::DATA_W-1:0] rc_q;
  logic [cipher_pkg::ADDR_W-1:0]                           base;
  logic                                                    lane_end;
  logic                                                    rsp_last;

  assign lane_end = issue_q && (str_q == STR_RC);
  // Last word of a beat comes back from memory
  assign rsp_last = rsp_valid_q && (rsp_str_q == STR_RC) && (rsp_lane_q == cipher_pkg::LAST_LANE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      issue_q      <= 1'b0;
      str_q        <= STR_TEXT;
      lane_q       <= '0;
      word_q       <= '0;
      issue_beat_q <= '0;
      beat_cnt_q   <= '0;
      text_base_q  <= '0;
      num_beats_q  <= '0;
      rsp_valid_q  <= 1'b0;
      rsp_str_q    <= STR_TEXT;
      rsp_lane_q   <= '0;
      beat_valid_q <= 1'b0;
    end else begin
      // Tag of the word returning next cycle
      rsp_valid_q  <= issue_q;
      rsp_str_q    <= str_q;
      rsp_lane_q   <= lane_q;
      beat_valid_q <= rsp_last;
      if (ctrl.req_start) begin
        busy_q       <= 1'b1;
        issue_q      <= 1'b1;
        str_q        <= STR_TEXT;
        lane_q       <= '0;
        word_q       <= '0;
        issue_beat_q <= '0;
        beat_cnt_q   <= '0;
        text_base_q  <= ctrl.base_addr;
        num_beats_q  <= ctrl.num_beats;
      end else begin
        if (issue_q && !lane_end) begin
          str_q <= stream_e'(str_q + 2'd1);
        end
        if (lane_end) begin
          str_q  <= STR_TEXT;
          lane_q <= lane_q + 1'b1;
          word_q <= word_q + 1'b1;
          if (lane_q == cipher_pkg::LAST_LANE) begin
            issue_beat_q <= issue_beat_q + 1'b1;
            if ((issue_beat_q + 1'b1) == num_beats_q) begin
              issue_q <= 1'b0;
            end
          end
        end
        if (rsp_last) begin
          beat_cnt_q <= beat_cnt_q + 1'b1;
          if ((beat_cnt_q + 1'b1) == num_beats_q) begin
            busy_q <= 1'b0;
          end
        end
      end
    end
  end

  // Beat registers
  always_ff @(posedge clk_i) begin
    if (rsp_valid_q) begin
      case (rsp_str_q)
        STR_TEXT: text_q[rsp_lane_q] <= rd_data_i;
        STR_KEY:  key_q[rsp_lane_q]  <= rd_data_i;
        default:  rc_q[rsp_lane_q]   <= rd_data_i;
      endcase
    end
  end

  always_comb begin
    case (str_q)
      STR_TEXT: base = text_base_q;
      STR_KEY:  base = cfg_i.key_base;
      default:  base = cfg_i.rc_base;
    endcase
  end

  assign rd_req_o  = issue_q;
  assign rd_addr_o = base + word_q;

  assign ctrl.ready_start = !busy_q;
  assign ctrl.beat_cnt    = beat_cnt_q;

  assign beat.beat_valid = beat_valid_q;
  assign beat.text       = text_q;
  assign beat.key        = key_q;
  assign beat.rc         = rc_q;

endmodule

`default_nettype wire

// File: ctrl/cipher_ctrl_fsm.sv
/*
 * Job sequencer
 * Launches the streamers, waits for the last output beat, signals done
 */
`timescale 1ns/100ps
`default_nettype none

module cipher_ctrl_fsm (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  cipher_pkg::cipher_cfg_t cfg_i,
  stream_ctrl_if.ctrl             src_ctrl,
  stream_ctrl_if.ctrl             snk_ctrl,
  output logic                    busy_o,
  output logic                    done_o
);

  cipher_pkg::ctrl_state_e state_q;
  cipher_pkg::ctrl_state_e state_d;
  logic                    both_ready;
  logic                    start_req;

  assign both_ready = src_ctrl.ready_start && snk_ctrl.ready_start;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= cipher_pkg::CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d   = state_q;
    start_req = 1'b0;
    done_o    = 1'b0;
    case (state_q)
      cipher_pkg::CTRL_IDLE: begin
        if (start_i) begin
          state_d = cipher_pkg::CTRL_START;
        end
      end
      cipher_pkg::CTRL_START: begin
        // Launch at once if both streamers are idle
        if (both_ready) begin
          start_req = 1'b1;
          state_d   = cipher_pkg::CTRL_COMPUTE;
        end else begin
          state_d = cipher_pkg::CTRL_WAIT;
        end
      end
      cipher_pkg::CTRL_WAIT: begin
        if (both_ready) begin
          start_req = 1'b1;
          state_d   = cipher_pkg::CTRL_COMPUTE;
        end
      end
      cipher_pkg::CTRL_COMPUTE: begin
        // Sink counter was cleared by req_start
        if (snk_ctrl.beat_cnt == cfg_i.num_beats) begin
          state_d = cipher_pkg::CTRL_TERMINATE;
        end
      end
      cipher_pkg::CTRL_TERMINATE: begin
        if (both_ready) begin
          done_o  = 1'b1;
          state_d = cipher_pkg::CTRL_IDLE;
        end
      end
      default: state_d = cipher_pkg::CTRL_IDLE;
    endcase
  end

  // Both streamers start on the same cycle
  assign src_ctrl.req_start = start_req;
  assign snk_ctrl.req_start = start_req;
  assign src_ctrl.base_addr = cfg_i.text_base;
  assign snk_ctrl.base_addr = cfg_i.out_base;
  assign src_ctrl.num_beats = cfg_i.num_beats;
  assign snk_ctrl.num_beats = cfg_i.num_beats;

  assign busy_o = (state_q != cipher_pkg::CTRL_IDLE);

  // Launched streamers drop ready until their job is over
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_req |=> !src_ctrl.ready_start && !snk_ctrl.ready_start);

  // A zero length job would never reach the beat count
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == cipher_pkg::CTRL_IDLE && start_i) |-> cfg_i.num_beats != '0);

endmodule

`default_nettype wire

// File: ctrl/cipher_regfile.sv
/*
 * Configuration register bank
 * Stream bases and job length, frozen while a job is running
 */
`timescale 1ns/100ps
`default_nettype none

module cipher_regfile (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cfg_we_i,
  input  cipher_pkg::reg_addr_e         cfg_addr_i,
  input  logic [cipher_pkg::DATA_W-1:0] cfg_wdata_i,
  input  logic                          busy_i,
  output cipher_pkg::cipher_cfg_t       cfg_o
);

  cipher_pkg::cipher_cfg_t cfg_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (cfg_we_i && !busy_i) begin
      case (cfg_addr_i)
        cipher_pkg::REG_TEXT: cfg_q.text_base <= cfg_wdata_i[cipher_pkg::ADDR_W-1:0];
        cipher_pkg::REG_KEY:  cfg_q.key_base  <= cfg_wdata_i[cipher_pkg::ADDR_W-1:0];
        cipher_pkg::REG_RC:   cfg_q.rc_base   <= cfg_wdata_i[cipher_pkg::ADDR_W-1:0];
        cipher_pkg::REG_OUT:  cfg_q.out_base  <= cfg_wdata_i[cipher_pkg::ADDR_W-1:0];
        cipher_pkg::REG_LEN:  cfg_q.num_beats <= cfg_wdata_i[cipher_pkg::LEN_W-1:0];
        default: ;
      endcase
    end
  end

  assign cfg_o = cfg_q;

  // Host writes must hit a mapped register
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_we_i |-> cfg_addr_i inside {cipher_pkg::REG_TEXT, cipher_pkg::REG_KEY,
                                    cipher_pkg::REG_RC, cipher_pkg::REG_OUT,
                                    cipher_pkg::REG_LEN});

endmodule

`default_nettype wire

// File: common/lane_bus_if.sv
/*
 * Lane operand bus
 * One beat of text, key and constant words with its valid pulse
 */
`timescale 1ns/100ps
`default_nettype none

interface lane_bus_if;

  logic beat_valid;
  // One word per lane
  logic [cipher_pkg::NUM_LANES-1:0][cipher_pkg::DATA_W-1:0] text;
  logic [cipher_pkg::NUM_LANES-1:0][cipher_pkg::DATA_W-1:0] key;
  logic [cipher_pkg::NUM_LANES-1:0][cipher_pkg::DATA_W-1:0] rc;

  modport src (
    output beat_valid,
    output text,
    output key,
    output rc
  );

  modport lane (
    input beat_valid,
    input text,
    input key,
    input rc
  );

endinterface

`default_nettype wire

// File: common/stream_ctrl_if.sv
/*
 * Streamer control interface
 * Start request and job bounds from the sequencer, status back
 */
`timescale 1ns/100ps
`default_nettype none

interface stream_ctrl_if;

  logic                         req_start;
  logic [cipher_pkg::ADDR_W-1:0] base_addr;
  logic [cipher_pkg::LEN_W-1:0]  num_beats;
  logic                         ready_start;
  // Beats completed since the last req_start
  logic [cipher_pkg::LEN_W-1:0]  beat_cnt;

  modport ctrl (
    output req_start,
    output base_addr,
    output num_beats,
    input  ready_start,
    input  beat_cnt
  );

  modport streamer (
    input  req_start,
    input  base_addr,
    input  num_beats,
    output ready_start,
    output beat_cnt
  );

endinterface

`default_nettype wire

// File: common/cipher_pkg.sv
/*
 * Cipher accelerator package
 * Sizes, register map, control states and the job configuration
 */
`default_nettype none

package cipher_pkg;

  // Datapath and stream sizes
  localparam int NUM_LANES = 4;
  localparam int DATA_W    = 32;
  localparam int ADDR_W    = 16;
  localparam int LEN_W     = 16;
  localparam int ROT_AMT   = 5;

  // Lane index width and the index of the last lane in a beat
  localparam int                LANE_W    = $clog2(NUM_LANES);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(NUM_LANES - 1);

  // Configuration register map
  typedef enum logic [2:0] {
    REG_TEXT = 3'd0,
    REG_KEY  = 3'd1,
    REG_RC   = 3'd2,
    REG_OUT  = 3'd3,
    REG_LEN  = 3'd4
  } reg_addr_e;

  // Job sequencer states
  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_START,
    CTRL_WAIT,
    CTRL_COMPUTE,
    CTRL_TERMINATE
  } ctrl_state_e;

  // Word base addresses of the four streams and the job length in beats
  typedef struct packed {
    logic [ADDR_W-1:0] text_base;
    logic [ADDR_W-1:0] key_base;
    logic [ADDR_W-1:0] rc_base;
    logic [ADDR_W-1:0] out_base;
    logic [LEN_W-1:0]  num_beats;
  } cipher_cfg_t;

endpackage

`default_nettype wire
